// ==== cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    typedef logic [31:0] word;
    typedef logic [4:0]  regAddr;

    localparam int     regCount    = 32;
    localparam regAddr regLink     = 5'd31;
    localparam word    resetVector = 32'h0000_0000;

    // primary opcodes, instr[31:26]
    typedef enum logic [5:0] {
        OP_ALU    = 6'h00,
        OP_BRANCH = 6'h01,
        OP_J      = 6'h02,
        OP_JAL    = 6'h03,
        OP_BEQ    = 6'h04,
        OP_BNE    = 6'h05,
        OP_BLEZ   = 6'h06,
        OP_BGTZ   = 6'h07,
        OP_ADDI   = 6'h08,
        OP_ADDIU  = 6'h09,
        OP_SLTI   = 6'h0a,
        OP_SLTIU  = 6'h0b,
        OP_ANDI   = 6'h0c,
        OP_ORI    = 6'h0d,
        OP_XORI   = 6'h0e,
        OP_LUI    = 6'h0f,
        OP_MULL   = 6'h1c,
        OP_LW     = 6'h23,
        OP_SW     = 6'h2b
    } opCodeT;

    // raw regimm codes from instr[20:16]
    localparam logic [5:0] RI_BLTZ   = 6'h00;
    localparam logic [5:0] RI_BGEZ   = 6'h01;
    localparam logic [5:0] RI_BLTZAL = 6'h10;
    localparam logic [5:0] RI_BGEZAL = 6'h11;

    // raw special2 codes from instr[5:0]
    localparam logic [5:0] S2_MADD  = 6'h00;
    localparam logic [5:0] S2_MADDU = 6'h01;
    localparam logic [5:0] S2_MUL   = 6'h02;
    localparam logic [5:0] S2_MSUB  = 6'h04;
    localparam logic [5:0] S2_MSUBU = 6'h05;
    localparam logic [5:0] S2_CLZ   = 6'h20;
    localparam logic [5:0] S2_CLO   = 6'h21;

    // unified function codes; R-type keeps its funct value,
    // branch and special2 codes move into unused funct slots
    typedef enum logic [5:0] {
        FN_SLL    = 6'h00,
        FN_SRL    = 6'h02,
        FN_SRA    = 6'h03,
        FN_SLLV   = 6'h04,
        FN_SRLV   = 6'h06,
        FN_SRAV   = 6'h07,
        FN_JR     = 6'h08,
        FN_JALR   = 6'h09,
        FN_MOVZ   = 6'h0a,
        FN_MOVN   = 6'h0b,
        FN_MFHI   = 6'h10,
        FN_MTHI   = 6'h11,
        FN_MFLO   = 6'h12,
        FN_MTLO   = 6'h13,
        FN_MULT   = 6'h18,
        FN_MULTU  = 6'h19,
        FN_ADD    = 6'h20,
        FN_ADDU   = 6'h21,
        FN_SUB    = 6'h22,
        FN_SUBU   = 6'h23,
        FN_AND    = 6'h24,
        FN_OR     = 6'h25,
        FN_XOR    = 6'h26,
        FN_NOR    = 6'h27,
        FN_SLT    = 6'h2a,
        FN_SLTU   = 6'h2b,
        FN_BLTZ   = 6'h2c,
        FN_BGEZ   = 6'h2d,
        FN_BLTZAL = 6'h2e,
        FN_BGEZAL = 6'h2f,
        FN_MADD   = 6'h30,
        FN_MADDU  = 6'h31,
        FN_MSUB   = 6'h32,
        FN_MSUBU  = 6'h33,
        FN_BEQ    = 6'h34,
        FN_BNE    = 6'h35,
        FN_BLEZ   = 6'h36,
        FN_BGTZ   = 6'h37,
        FN_MUL    = 6'h3a,
        FN_CLO    = 6'h3c,
        FN_CLZ    = 6'h3d
    } funcCodeT;

endpackage

`default_nettype wire

// ==== decoder.sv ====
`default_nettype none

module decoder
    import cpuPkg::*;
(
    input  opCodeT     opCode,
    input  funcCodeT   funcCode,
    output logic [1:0] regDst,
    output logic       branch,
    output logic       jump,
    output logic       memRead,
    output logic       memToReg,
    output logic       aluOp,
    output logic       mulOp,
    output logic       memWrite,
    output logic       aluSrc,
    output logic       regWrite,
    output logic       shiftSel,
    output logic       immSize,
    output logic       unsgnSel,
    output funcCodeT   func
);

    always_comb
    begin
        regDst   = 2'd0;
        branch   = 1'b0;
        jump     = 1'b0;
        memRead  = 1'b0;
        memToReg = 1'b0;
        aluOp    = 1'b0;
        mulOp    = 1'b0;
        memWrite = 1'b0;
        aluSrc   = 1'b0;
        regWrite = 1'b0;
        shiftSel = 1'b0;
        immSize  = 1'b0;
        unsgnSel = 1'b0;
        func     = FN_SLL;

        case (opCode)
            OP_ALU:
                case (funcCode)
                    FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLL, FN_SLLV,
                    FN_SRA, FN_SRAV, FN_SRL, FN_SRLV, FN_AND, FN_NOR,
                    FN_OR, FN_XOR, FN_MOVN, FN_MOVZ, FN_SLT, FN_SLTU,
                    FN_MFHI, FN_MFLO:
                    begin
                        regDst   = 2'd1;
                        func     = funcCode;
                        aluOp    = 1'b1;
                        regWrite = 1'b1;
                    end
                    // HI/LO writers, no register write-back
                    FN_MULT, FN_MULTU, FN_MTHI, FN_MTLO:
                    begin
                        func  = funcCode;
                        aluOp = 1'b1;
                    end
                    FN_JALR:
                    begin
                        regDst   = 2'd1;
                        func     = FN_JALR;
                        jump     = 1'b1;
                        regWrite = 1'b1;
                    end
                    FN_JR:
                    begin
                        func = FN_JR;
                        jump = 1'b1;
                    end
                    default:;
                endcase

            OP_BRANCH:
            begin
                case (funcCode)
                    RI_BGEZ:   func = FN_BGEZ;
                    RI_BLTZ:   func = FN_BLTZ;
                    RI_BGEZAL: func = FN_BGEZAL;
                    RI_BLTZAL: func = FN_BLTZAL;
                    default:;
                endcase
                if (func != FN_SLL)
                begin
                    branch = 1'b1;
                    aluSrc = 1'b1;
                end
                // linking forms always write pc+4 to r31
                if (func == FN_BGEZAL || func == FN_BLTZAL)
                begin
                    regDst   = 2'd2;
                    regWrite = 1'b1;
                end
            end

            OP_MULL:
            begin
                mulOp = 1'b1;
                case (funcCode)
                    S2_CLO:   func = FN_CLO;
                    S2_CLZ:   func = FN_CLZ;
                    S2_MUL:   func = FN_MUL;
                    S2_MADD:  func = FN_MADD;
                    S2_MADDU: func = FN_MADDU;
                    S2_MSUB:  func = FN_MSUB;
                    S2_MSUBU: func = FN_MSUBU;
                    default:  mulOp = 1'b0;
                endcase
                if (func == FN_CLO || func == FN_CLZ || func == FN_MUL)
                begin
                    regDst   = 2'd1;
                    regWrite = 1'b1;
                end
            end

            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
            begin
                aluOp    = 1'b1;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                // logic immediates zero-extend, the rest sign-extend
                unsgnSel = (opCode == OP_ANDI) || (opCode == OP_ORI) || (opCode == OP_XORI);
                shiftSel = (opCode == OP_LUI);
                case (opCode)
                    OP_SLTI:  func = FN_SLT;
                    OP_SLTIU: func = FN_SLTU;
                    OP_ANDI:  func = FN_AND;
                    OP_ORI:   func = FN_OR;
                    OP_XORI:  func = FN_XOR;
                    default:  func = FN_ADD;
                endcase
            end

            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ:
            begin
                case (opCode)
                    OP_BEQ:  func = FN_BEQ;
                    OP_BNE:  func = FN_BNE;
                    OP_BLEZ: func = FN_BLEZ;
                    default: func = FN_BGTZ;
                endcase
                branch = 1'b1;
                aluSrc = 1'b1;
            end

            OP_J, OP_JAL:
            begin
                jump    = 1'b1;
                aluSrc  = 1'b1;
                immSize = 1'b1;
                if (opCode == OP_JAL)
                begin
                    regDst   = 2'd2;
                    regWrite = 1'b1;
                end
            end

            // address is rs + offset through the ALU
            OP_LW:
            begin
                func     = FN_ADD;
                aluOp    = 1'b1;
                aluSrc   = 1'b1;
                memRead  = 1'b1;
                memToReg = 1'b1;
                regWrite = 1'b1;
            end

            OP_SW:
            begin
                func     = FN_ADD;
                aluOp    = 1'b1;
                aluSrc   = 1'b1;
                memWrite = 1'b1;
            end

            default:;
        endcase
    end

endmodule

`default_nettype wire

// ==== alu.sv ====
`default_nettype none

module alu
    import cpuPkg::*;
(
    input  funcCodeT   func,
    input  logic       aluOp,
    input  word        a,
    input  word        b,
    input  logic [4:0] shamt,
    input  word        hi,
    input  word        lo,
    output word        result,
    output logic       writeSuppress
);

    word        aluValue;
    logic       countOnes;
    logic       found;
    logic [5:0] leadCount;

    always_comb
    begin
        case (func)
            FN_ADD, FN_ADDU: aluValue = a + b;
            FN_SUB, FN_SUBU: aluValue = a - b;
            FN_AND:          aluValue = a & b;
            FN_OR:           aluValue = a | b;
            FN_XOR:          aluValue = a ^ b;
            FN_NOR:          aluValue = ~(a | b);
            FN_SLL:          aluValue = b << shamt;
            FN_SLLV:         aluValue = b << a[4:0];
            FN_SRL:          aluValue = b >> shamt;
            FN_SRLV:         aluValue = b >> a[4:0];
            FN_SRA:          aluValue = $signed(b) >>> shamt;
            FN_SRAV:         aluValue = $signed(b) >>> a[4:0];
            FN_SLT:          aluValue = {31'b0, $signed(a) < $signed(b)};
            FN_SLTU:         aluValue = {31'b0, a < b};
            FN_MOVN, FN_MOVZ: aluValue = a;
            FN_MFHI:         aluValue = hi;
            FN_MFLO:         aluValue = lo;
            default:         aluValue = '0;
        endcase
    end

    // count leading ones or zeros of rs
    assign countOnes = (func == FN_CLO);

    always_comb
    begin
        leadCount = 6'd32;
        found     = 1'b0;
        for (int i = 31; i >= 0; i--)
        begin
            if (!found && (a[i] != countOnes))
            begin
                leadCount = 6'(31 - i);
                found     = 1'b1;
            end
        end
    end

    assign result = aluOp ? aluValue : {26'b0, leadCount};

    // conditional move fails: movn needs rt != 0, movz needs rt == 0
    assign writeSuppress = aluOp && (((func == FN_MOVN) && (b == '0)) ||
                                     ((func == FN_MOVZ) && (b != '0)));

endmodule

`default_nettype wire

// ==== registerFile.sv ====
`default_nettype none

module registerFile
    import cpuPkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  regAddr readAddrA,
    input  regAddr readAddrB,
    input  regAddr writeAddr,
    input  word    writeData,
    input  logic   writeEnable,
    output word    readDataA,
    output word    readDataB
);

    word regs [regCount];

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            for (int i = 0; i < regCount; i++)
                regs[i] <= '0;
        end
        else if (writeEnable && (writeAddr != '0))
            regs[writeAddr] <= writeData;
    end

    // r0 is hardwired to zero
    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

`default_nettype wire

// ==== mulUnit.sv ====
`default_nettype none

module mulUnit
    import cpuPkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  funcCodeT func,
    input  logic     aluOp,
    input  logic     mulOp,
    input  word      a,
    input  word      b,
    output word      hi,
    output word      lo,
    output word      mulResult
);

    logic [63:0] prodSigned;
    logic [63:0] prodUnsigned;

    assign prodSigned   = 64'($signed(a)) * 64'($signed(b));
    assign prodUnsigned = 64'(a) * 64'(b);

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            hi <= '0;
            lo <= '0;
        end
        else if (aluOp)
        begin
            case (func)
                FN_MULT:  {hi, lo} <= prodSigned;
                FN_MULTU: {hi, lo} <= prodUnsigned;
                FN_MTHI:  hi <= a;
                FN_MTLO:  lo <= a;
                default:;
            endcase
        end
    end

    // mul writes rd only, HI/LO untouched
    assign mulResult = (mulOp && (func == FN_MUL)) ? prodSigned[31:0] : '0;

endmodule

`default_nettype wire

// ==== branchUnit.sv ====
`default_nettype none

module branchUnit
    import cpuPkg::*;
(
    input  word         pc,
    input  word         rsData,
    input  word         rtData,
    input  word         imm,
    input  logic [25:0] index,
    input  funcCodeT    func,
    input  logic        branch,
    input  logic        jump,
    input  logic        immSize,
    output word         nextPc
);

    word  pcPlus4;
    word  branchTarget;
    word  jumpTarget;
    logic rsNeg;
    logic rsZero;
    logic condition;

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {imm[29:0], 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], index, 2'b00};

    assign rsNeg  = rsData[31];
    assign rsZero = (rsData == '0);

    always_comb
    begin
        case (func)
            FN_BEQ:               condition = (rsData == rtData);
            FN_BNE:               condition = (rsData != rtData);
            FN_BLEZ:              condition = rsNeg || rsZero;
            FN_BGTZ:              condition = !rsNeg && !rsZero;
            FN_BGEZ, FN_BGEZAL:   condition = !rsNeg;
            FN_BLTZ, FN_BLTZAL:   condition = rsNeg;
            default:              condition = 1'b0;
        endcase
    end

    always_comb
    begin
        if (branch && condition)
            nextPc = branchTarget;
        else if (jump && immSize)
            nextPc = jumpTarget;
        // jr and jalr
        else if (jump)
            nextPc = rsData;
        else
            nextPc = pcPlus4;
    end

endmodule

`default_nettype wire

// ==== cpuCore.sv ====
`default_nettype none

module cpuCore
    import cpuPkg::*;
(
    input  logic clock,
    input  logic reset,
    output word  pc,
    input  word  instr,
    output word  memAddr,
    output word  memWriteData,
    output logic memWrite,
    output logic memRead,
    input  word  memReadData
);

    opCodeT     opField;
    funcCodeT   rawFunc;
    funcCodeT   func;
    logic [1:0] regDst;
    logic       branch;
    logic       jump;
    logic       memToReg;
    logic       aluOp;
    logic       mulOp;
    logic       aluSrc;
    logic       regWrite;
    logic       shiftSel;
    logic       immSize;
    logic       unsgnSel;

    regAddr     rs;
    regAddr     rt;
    regAddr     rd;
    regAddr     writeAddr;
    word        rsData;
    word        rtData;
    word        writeData;
    word        immExt;
    word        immValue;
    word        aluB;
    word        aluResult;
    word        hi;
    word        lo;
    word        mulResult;
    word        nextPc;
    word        pcPlus4;
    logic       writeSuppress;
    logic       linkBranch;

    assign opField = opCodeT'(instr[31:26]);
    assign rs      = instr[25:21];
    assign rt      = instr[20:16];
    assign rd      = instr[15:11];

    // regimm selects the branch kind through the rt field
    assign rawFunc = (opField == OP_BRANCH) ? funcCodeT'({1'b0, instr[20:16]})
                                            : funcCodeT'(instr[5:0]);

    decoder u_decoder (
        .opCode   (opField),
        .funcCode (rawFunc),
        .regDst   (regDst),
        .branch   (branch),
        .jump     (jump),
        .memRead  (memRead),
        .memToReg (memToReg),
        .aluOp    (aluOp),
        .mulOp    (mulOp),
        .memWrite (memWrite),
        .aluSrc   (aluSrc),
        .regWrite (regWrite),
        .shiftSel (shiftSel),
        .immSize  (immSize),
        .unsgnSel (unsgnSel),
        .func     (func)
    );

    assign immExt   = unsgnSel ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
    assign immValue = shiftSel ? {instr[15:0], 16'b0} : immExt;

    // branches compare both registers in the branch unit
    assign aluB = (aluSrc && !branch) ? immValue : rtData;

    always_comb
    begin
        case (regDst)
            2'd1:    writeAddr = rd;
            2'd2:    writeAddr = regLink;
            default: writeAddr = rt;
        endcase
    end

    registerFile u_registerFile (
        .clock       (clock),
        .reset       (reset),
        .readAddrA   (rs),
        .readAddrB   (rt),
        .writeAddr   (writeAddr),
        .writeData   (writeData),
        .writeEnable (regWrite && !writeSuppress),
        .readDataA   (rsData),
        .readDataB   (rtData)
    );

    alu u_alu (
        .func          (func),
        .aluOp         (aluOp),
        .a             (rsData),
        .b             (aluB),
        .shamt         (instr[10:6]),
        .hi            (hi),
        .lo            (lo),
        .result        (aluResult),
        .writeSuppress (writeSuppress)
    );

    mulUnit u_mulUnit (
        .clock     (clock),
        .reset     (reset),
        .func      (func),
        .aluOp     (aluOp),
        .mulOp     (mulOp),
        .a         (rsData),
        .b         (rtData),
        .hi        (hi),
        .lo        (lo),
        .mulResult (mulResult)
    );

    branchUnit u_branchUnit (
        .pc      (pc),
        .rsData  (rsData),
        .rtData  (rtData),
        .imm     (immValue),
        .index   (instr[25:0]),
        .func    (func),
        .branch  (branch),
        .jump    (jump),
        .immSize (immSize),
        .nextPc  (nextPc)
    );

    assign pcPlus4    = pc + 32'd4;
    assign linkBranch = branch && ((func == FN_BGEZAL) || (func == FN_BLTZAL));

    always_comb
    begin
        if (jump || linkBranch)
            writeData = pcPlus4;
        else if (memToReg)
            writeData = memReadData;
        else if (mulOp && (func == FN_MUL))
            writeData = mulResult;
        else
            writeData = aluResult;
    end

    assign memAddr      = aluResult;
    assign memWriteData = rtData;

    always_ff @(posedge clock)
    begin
        if (reset)
            pc <= resetVector;
        else
            pc <= nextPc;
    end

endmodule

`default_nettype wire

// ==== tbCpu.sv ====
`default_nettype none

module tbCpu;
    import cpuPkg::*;

    // six programs of up to ~40 instructions plus 5 reset cycles each and some margin
    localparam int cycleLimit = 600;
    localparam word haltWord  = 32'h1000_ffff;
    localparam word nopWord   = 32'h0000_0000;

    logic clock;
    logic reset;
    word  pc;
    word  instr;
    word  memAddr;
    word  memWriteData;
    logic memWrite;
    logic memRead;
    word  memReadData;

    word  rom [256];
    word  ram [256];
    logic ramReady = 1'b0;
    word  logAddr [$];
    word  logData [$];
    int   logStart;
    int   cycles = 0;
    int   seed;
    int   readCount = 0;
    int   readStart;
    int   expReads;

    word  prog [$];
    word  expAddr [$];
    word  expVal [$];
    word  jumpFrom [$];
    word  jumpTo [$];
    word  haltPc;
    int   slot;

    cpuCore dut (
        .clock        (clock),
        .reset        (reset),
        .pc           (pc),
        .instr        (instr),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memWrite     (memWrite),
        .memRead      (memRead),
        .memReadData  (memReadData)
    );

    assign instr       = rom[pc[9:2]];
    assign memReadData = ram[memAddr[9:2]];

    initial
    begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // data RAM is filled on the first edge and then written by SW outside reset
    always @(posedge clock)
    begin
        if (!ramReady)
        begin
            for (int i = 0; i < 256; i++)
                ram[i] <= 32'ha5a5_0000 ^ 32'(i);
            ramReady <= 1'b1;
        end
        else if (memWrite && !reset)
        begin
            ram[memAddr[9:2]] <= memWriteData;
            logAddr.push_back(memAddr);
            logData.push_back(memWriteData);
        end
    end

    // loads seen outside reset
    always @(posedge clock)
    begin
        if (memRead && !reset)
            readCount <= readCount + 1;
    end

    always @(posedge clock)
    begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit)
        begin
            $display("run hung, cycle limit of %0d reached at pc %h", cycleLimit, pc);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    function automatic word rType(input regAddr rs, input regAddr rt, input regAddr rd,
                                  input logic [4:0] sh, input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic word iType(input logic [5:0] op, input regAddr rs, input regAddr rt,
                                  input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word jType(input logic [5:0] op, input logic [25:0] idx);
        return {op, idx};
    endfunction

    function automatic word s2Type(input regAddr rs, input regAddr rt, input regAddr rd,
                                   input logic [5:0] fn);
        return {6'h1c, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word countLeading(input word v, input logic ones);
        int n;
        n = 0;
        while (n < 32 && v[31 - n] == ones)
            n++;
        return 32'(n);
    endfunction

    task automatic checkWord(input string name, input word expected, input word actual);
        if (expected !== actual)
        begin
            $display("mismatch in %s: expected %h, actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "data check");
        end
    endtask

    task automatic checkPc(input string name, input word expected, input word actual);
        if (expected !== actual)
        begin
            $display("mismatch in %s pc: expected %h, actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "pc check");
        end
    endtask

    task automatic emit(input word w);
        prog.push_back(w);
    endtask

    task automatic loadConst(input regAddr r, input word v);
        emit(iType(OP_LUI, 5'd0, r, v[31:16]));
        emit(iType(OP_ORI, r, r, v[15:0]));
    endtask

    task automatic expectAt(input word addr, input word val);
        expAddr.push_back(addr);
        expVal.push_back(val);
    endtask

    // store a register into the next result slot
    task automatic storeReg(input regAddr r, input word val);
        word addr;
        addr = 32'h100 + 32'(slot) * 4;
        emit(iType(OP_SW, 5'd0, r, addr[15:0]));
        expectAt(addr, val);
        slot++;
    endtask

    task automatic aluStep(input word ins, input word val);
        emit(ins);
        storeReg(5'd3, val);
    endtask

    task automatic recordJump(input word from, input word to);
        jumpFrom.push_back(from);
        jumpTo.push_back(to);
    endtask

    // branch with offset 1 over one nop
    task automatic emitBranch(input word ins, input logic taken);
        word addr;
        addr = 32'(prog.size()) * 4;
        recordJump(addr, taken ? addr + 8 : addr + 4);
        emit(ins);
        emit(nopWord);
    endtask

    task automatic startProgram();
        emit(haltWord);
        haltPc = 32'(prog.size() - 1) * 4;
        @(posedge clock);
        reset <= 1'b1;
        for (int i = 0; i < 256; i++)
            rom[i] = (i < prog.size()) ? prog[i] : haltWord;
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        logStart  = logAddr.size();
        readStart = readCount;
        @(negedge clock);
    endtask

    task automatic waitPc(input word addr);
        while (pc !== addr)
            @(negedge clock);
    endtask

    task automatic finishProgram(input string name);
        int found;
        for (int j = 0; j < jumpFrom.size(); j++)
        begin
            waitPc(jumpFrom[j]);
            @(negedge clock);
            checkPc(name, jumpTo[j], pc);
        end
        waitPc(haltPc);
        for (int j = 0; j < expAddr.size(); j++)
        begin
            found = -1;
            for (int k = logStart; k < logAddr.size(); k++)
                if (logAddr[k] == expAddr[j])
                    found = k;
            if (found < 0)
            begin
                $display("%s: no store to address %h was seen", name, expAddr[j]);
                $display("Test failed");
                $fatal(1, "missing store");
            end
            checkWord(name, expVal[j], logData[found]);
        end
        checkWord({name, " loads"}, word'(expReads), word'(readCount - readStart));
        prog.delete();
        expAddr.delete();
        expVal.delete();
        jumpFrom.delete();
        jumpTo.delete();
        slot     = 0;
        expReads = 0;
    endtask

    task automatic testArith();
        word a;
        word b;
        word kRaw;
        word sk;
        word zk;
        a    = $random(seed);
        b    = $random(seed);
        kRaw = $random(seed);
        sk   = {{16{kRaw[15]}}, kRaw[15:0]};
        zk   = {16'h0, kRaw[15:0]};
        loadConst(5'd1, a);
        loadConst(5'd2, b);
        aluStep(iType(OP_ADDI, 5'd1, 5'd3, kRaw[15:0]), a + sk);
        aluStep(iType(OP_ADDIU, 5'd1, 5'd3, kRaw[15:0]), a + sk);
        aluStep(iType(OP_LUI, 5'd0, 5'd3, kRaw[15:0]), {kRaw[15:0], 16'h0});
        aluStep(iType(OP_ANDI, 5'd1, 5'd3, kRaw[15:0]), a & zk);
        aluStep(iType(OP_ORI, 5'd1, 5'd3, kRaw[15:0]), a | zk);
        aluStep(iType(OP_XORI, 5'd1, 5'd3, kRaw[15:0]), a ^ zk);
        aluStep(rType(5'd1, 5'd2, 5'd3, 5'd0, FN_ADD), a + b);
        aluStep(rType(5'd1, 5'd2, 5'd3, 5'd0, FN_SUB), a - b);
        aluStep(rType(5'd1, 5'd2, 5'd3, 5'd0, FN_AND), a & b);
        aluStep(rType(5'd1, 5'd2, 5'd3, 5'd0, FN_OR), a | b);
        aluStep(rType(5'd1, 5'd2, 5'd3, 5'd0, FN_XOR), a ^ b);
        aluStep(rType(5'd1, 5'd2, 5'd3, 5'd0, FN_NOR), ~(a | b));
        startProgram();
        finishProgram("arith");
    endtask

    task automatic testShiftCompare();
        word c;
        c = $random(seed);
        emit(iType(OP_ADDIU, 5'd0, 5'd4, 16'd5));
        loadConst(5'd1, 32'h8000_0000);
        loadConst(5'd2, 32'h7fff_ffff);
        loadConst(5'd8, c);
        aluStep(rType(5'd0, 5'd2, 5'd3, 5'd3, FN_SLL), 32'hffff_fff8);
        aluStep(rType(5'd4, 5'd1, 5'd3, 5'd0, FN_SRAV), 32'hfc00_0000);
        aluStep(rType(5'd0, 5'd1, 5'd3, 5'd4, FN_SRL), 32'h0800_0000);
        aluStep(rType(5'd1, 5'd2, 5'd3, 5'd0, FN_SLT), 32'd1);
        aluStep(rType(5'd1, 5'd2, 5'd3, 5'd0, FN_SLTU), 32'd0);
        aluStep(rType(5'd8, 5'd2, 5'd3, 5'd0, FN_SLT), {31'd0, c != 32'h7fff_ffff});
        aluStep(iType(OP_SLTI, 5'd1, 5'd3, 16'hffff), 32'd1);
        aluStep(iType(OP_SLTIU, 5'd2, 5'd3, 16'hffff), 32'd1);
        aluStep(iType(OP_SLTIU, 5'd1, 5'd3, 16'h0001), 32'd0);
        // a suppressed conditional move keeps the old r5
        emit(iType(OP_ADDIU, 5'd0, 5'd5, 16'h1234));
        emit(rType(5'd2, 5'd4, 5'd5, 5'd0, FN_MOVN));
        storeReg(5'd5, 32'h7fff_ffff);
        emit(rType(5'd1, 5'd0, 5'd5, 5'd0, FN_MOVN));
        storeReg(5'd5, 32'h7fff_ffff);
        emit(rType(5'd1, 5'd0, 5'd5, 5'd0, FN_MOVZ));
        storeReg(5'd5, 32'h8000_0000);
        emit(rType(5'd2, 5'd4, 5'd5, 5'd0, FN_MOVZ));
        storeReg(5'd5, 32'h8000_0000);
        aluStep(s2Type(5'd1, 5'd3, 5'd3, S2_CLO), 32'd1);
        aluStep(s2Type(5'd2, 5'd3, 5'd3, S2_CLZ), 32'd1);
        aluStep(s2Type(5'd8, 5'd3, 5'd3, S2_CLZ), countLeading(c, 1'b0));
        aluStep(s2Type(5'd8, 5'd3, 5'd3, S2_CLO), countLeading(c, 1'b1));
        aluStep(s2Type(5'd0, 5'd3, 5'd3, S2_CLZ), 32'd32);
        startProgram();
        finishProgram("shiftCompare");
    endtask

    task automatic testLoadStore();
        word v [4];
        word off;
        emit(iType(OP_ADDIU, 5'd0, 5'd9, 16'h0200));
        for (int i = 0; i < 4; i++)
        begin
            v[i] = $random(seed);
            off  = 32'(i) * 8;
            loadConst(5'd1, v[i]);
            emit(iType(OP_SW, 5'd9, 5'd1, off[15:0]));
            expectAt(32'h200 + off, v[i]);
        end
        for (int i = 0; i < 4; i++)
        begin
            off = 32'(i) * 8;
            emit(iType(OP_LW, 5'd9, regAddr'(10 + i), off[15:0]));
            expReads++;
        end
        for (int i = 0; i < 4; i++)
            storeReg(regAddr'(10 + i), v[i]);
        startProgram();
        finishProgram("loadStore");
    endtask

    task automatic testBranch();
        word link;
        emit(iType(OP_ADDIU, 5'd0, 5'd1, 16'd5));
        emit(iType(OP_ADDIU, 5'd0, 5'd2, 16'd5));
        emit(iType(OP_ADDIU, 5'd0, 5'd3, 16'hfffd));
        emit(iType(OP_ADDIU, 5'd0, 5'd4, 16'd7));
        emitBranch(iType(OP_BEQ, 5'd1, 5'd2, 16'd1), 1'b1);
        emitBranch(iType(OP_BEQ, 5'd1, 5'd4, 16'd1), 1'b0);
        emitBranch(iType(OP_BNE, 5'd1, 5'd4, 16'd1), 1'b1);
        emitBranch(iType(OP_BNE, 5'd1, 5'd2, 16'd1), 1'b0);
        emitBranch(iType(OP_BLEZ, 5'd3, 5'd0, 16'd1), 1'b1);
        emitBranch(iType(OP_BLEZ, 5'd1, 5'd0, 16'd1), 1'b0);
        emitBranch(iType(OP_BGTZ, 5'd1, 5'd0, 16'd1), 1'b1);
        emitBranch(iType(OP_BGTZ, 5'd3, 5'd0, 16'd1), 1'b0);
        // regimm kinds sit in the rt field
        emitBranch(iType(OP_BRANCH, 5'd1, 5'h01, 16'd1), 1'b1);
        emitBranch(iType(OP_BRANCH, 5'd3, 5'h01, 16'd1), 1'b0);
        emitBranch(iType(OP_BRANCH, 5'd3, 5'h00, 16'd1), 1'b1);
        emitBranch(iType(OP_BRANCH, 5'd1, 5'h00, 16'd1), 1'b0);
        link = 32'(prog.size()) * 4 + 4;
        emitBranch(iType(OP_BRANCH, 5'd0, 5'h11, 16'd1), 1'b1);
        storeReg(5'd31, link);
        startProgram();
        finishProgram("branch");
    endtask

    task automatic testJump();
        word here;
        word dest;
        here = 32'(prog.size()) * 4;
        dest = here + 12;
        recordJump(here, dest);
        emit(jType(OP_J, dest[27:2]));
        emit(nopWord);
        emit(nopWord);
        here = 32'(prog.size()) * 4;
        dest = here + 8;
        recordJump(here, dest);
        emit(jType(OP_JAL, dest[27:2]));
        emit(nopWord);
        storeReg(5'd31, here + 4);
        here = 32'(prog.size()) * 4;
        dest = here + 12;
        emit(iType(OP_ADDIU, 5'd0, 5'd5, dest[15:0]));
        recordJump(here + 4, dest);
        emit(rType(5'd5, 5'd0, 5'd0, 5'd0, FN_JR));
        emit(nopWord);
        here = 32'(prog.size()) * 4;
        dest = here + 12;
        emit(iType(OP_ADDIU, 5'd0, 5'd6, dest[15:0]));
        recordJump(here + 4, dest);
        emit(rType(5'd6, 5'd0, 5'd7, 5'd0, FN_JALR));
        emit(nopWord);
        storeReg(5'd7, here + 8);
        startProgram();
        finishProgram("jump");
    endtask

    task automatic testMultiply();
        word         a;
        word         b;
        logic [63:0] ps;
        logic [63:0] pu;
        a  = $random(seed);
        b  = $random(seed);
        ps = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        pu = {32'h0, a} * {32'h0, b};
        loadConst(5'd1, a);
        loadConst(5'd2, b);
        emit(rType(5'd1, 5'd2, 5'd0, 5'd0, FN_MULT));
        aluStep(rType(5'd0, 5'd0, 5'd3, 5'd0, FN_MFHI), ps[63:32]);
        aluStep(rType(5'd0, 5'd0, 5'd3, 5'd0, FN_MFLO), ps[31:0]);
        emit(rType(5'd1, 5'd2, 5'd0, 5'd0, FN_MULTU));
        aluStep(rType(5'd0, 5'd0, 5'd3, 5'd0, FN_MFHI), pu[63:32]);
        aluStep(rType(5'd0, 5'd0, 5'd3, 5'd0, FN_MFLO), pu[31:0]);
        emit(rType(5'd1, 5'd0, 5'd0, 5'd0, FN_MTHI));
        emit(rType(5'd2, 5'd0, 5'd0, 5'd0, FN_MTLO));
        aluStep(rType(5'd0, 5'd0, 5'd3, 5'd0, FN_MFHI), a);
        aluStep(rType(5'd0, 5'd0, 5'd3, 5'd0, FN_MFLO), b);
        // MUL leaves HI and LO as MTHI/MTLO set them
        emit(s2Type(5'd1, 5'd2, 5'd8, S2_MUL));
        storeReg(5'd8, ps[31:0]);
        aluStep(rType(5'd0, 5'd0, 5'd3, 5'd0, FN_MFHI), a);
        aluStep(rType(5'd0, 5'd0, 5'd3, 5'd0, FN_MFLO), b);
        startProgram();
        finishProgram("multiply");
    endtask

    initial
    begin
        reset    = 1'b1;
        seed     = 35118;
        slot     = 0;
        expReads = 0;
        for (int i = 0; i < 256; i++)
            rom[i] = haltWord;
        testArith();
        testShiftCompare();
        testLoadStore();
        testBranch();
        testJump();
        testMultiply();
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
cpuPkg.sv
decoder.sv
alu.sv
registerFile.sv
mulUnit.sv
branchUnit.sv
cpuCore.sv
tbCpu.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --top-module tbCpu -f src.f -o simCpu
	./obj_dir/simCpu

clean:
	rm -rf obj_dir
